//--- run_sim.sh
#!/bin/sh
# build and run the ROM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_rom_subsystem \
	-o tb_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"

//--- sources.f
src/rom_pkg.sv
src/port_pkg.sv
src/download_writer.sv
src/rom_store.sv
src/rom_fetch.sv
src/rom_subsystem.sv
verif/tb_rom_subsystem.sv

//--- src/download_writer.sv
// ROM download writer
`timescale 1ns/1ps

module download_writer #(
	parameter int CPU_ADDR_W = 16,
	parameter int SND_ADDR_W = 14,
	localparam int WA_W = ((CPU_ADDR_W > SND_ADDR_W) ? CPU_ADDR_W : SND_ADDR_W) - 1
) (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         ioctl_download,
	input  logic                         ioctl_wr,
	input  logic [rom_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [rom_pkg::BYTE_W-1:0]   ioctl_dout,
	output logic                         p1_req,
	output logic                         p2_req,
	output logic [WA_W-1:0]              wr_addr,
	output logic [rom_pkg::DS_W-1:0]     wr_ds,
	output logic [rom_pkg::WORD_W-1:0]   wr_d,
	output logic                         rom_loaded,
	output logic                         game_reset
);

	logic                         wr_q;       // strobe delayed
	logic                         wr_edge;
	logic                         to_cpu;
	logic [rom_pkg::IOCTL_AW-1:0] snd_byte;   // byte offset inside the sound image
	port_pkg::access_op_e         op;
	logic                         dl_q;
	logic                         dl_end;

	// ========================================================================
	// byte stream to word writes
	// ========================================================================

	assign op       = ioctl_download ? port_pkg::OP_WRITE : port_pkg::OP_READ;
	assign wr_edge  = (op == port_pkg::OP_WRITE) && ioctl_wr && !wr_q;
	assign to_cpu   = ioctl_addr < rom_pkg::SND_BYTE_BASE;
	assign snd_byte = ioctl_addr - rom_pkg::SND_BYTE_BASE;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_q   <= 1'b0;
			p1_req <= 1'b0;
			p2_req <= 1'b0;
		end else begin
			wr_q <= ioctl_wr;
			if (wr_edge) begin
				// exactly one port per byte
				if (to_cpu)
					p1_req <= ~p1_req;
				else
					p2_req <= ~p2_req;
			end
		end
	end

	// held until the next strobe, well past the ack
	always_ff @(posedge clk_sys) begin
		if (wr_edge) begin
			wr_addr <= to_cpu ? ioctl_addr[WA_W:1] : snd_byte[WA_W:1];
			wr_ds   <= {ioctl_addr[0], ~ioctl_addr[0]};   // odd byte -> high half
			wr_d    <= {ioctl_dout, ioctl_dout};
		end
	end

	// ========================================================================
	// end of download
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dl_q       <= 1'b0;
			dl_end     <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			dl_q   <= ioctl_download;
			dl_end <= dl_q & ~ioctl_download;   // falling edge seen
			if (dl_end)
				rom_loaded <= 1'b1;
		end
	end

	// game stays in reset until the image is in place
	always_ff @(posedge clk_sys) begin
		game_reset <= rst | ~rom_loaded;
	end

endmodule

//--- src/port_pkg.sv
// Store port types
package port_pkg;

	// arbiter of the rom store
	typedef enum logic [1:0] {
		ST_IDLE,   // nothing granted
		ST_CPU,    // serving port 1
		ST_SND     // serving port 2
	} store_state_e;

	// one store access, carried on a port as its we level
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} access_op_e;

endpackage

//--- src/rom_fetch.sv
// ROM fetch port
`timescale 1ns/1ps

module rom_fetch #(
	parameter int ADDR_W = 16
) (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic [ADDR_W-1:0]          rom_addr,
	input  logic                       rom_rd,
	input  logic                       ack,
	input  logic [rom_pkg::WORD_W-1:0] q,
	output logic                       req,
	output logic [ADDR_W-2:0]          word_addr,   // last word requested
	output logic [rom_pkg::BYTE_W-1:0] rom_do,
	output logic                       ready
);

	logic                       busy;
	logic                       ack_exp;     // ack level that ends this fetch
	logic                       have_word;
	logic                       new_word;
	logic                       done;
	logic [rom_pkg::WORD_W-1:0] word_q;

	// nothing held yet, or the cpu moved to another word
	assign new_word = rom_rd && (!have_word || rom_addr[ADDR_W-1:1] != word_addr);
	assign done     = busy && (ack == ack_exp);
	assign ready    = !busy;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			req       <= 1'b0;
			busy      <= 1'b0;
			ack_exp   <= 1'b0;
			have_word <= 1'b0;
		end else if (busy) begin
			if (done)
				busy <= 1'b0;
		end else if (new_word) begin
			req       <= ~req;
			ack_exp   <= ~ack;   // store flips ack once for this request
			busy      <= 1'b1;
			have_word <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!busy && new_word)
			word_addr <= rom_addr[ADDR_W-1:1];   // stays put while pending
		if (done)
			word_q <= q;
	end

	// byte lane from the current address
	assign rom_do = rom_addr[0] ? word_q[rom_pkg::WORD_W-1:rom_pkg::BYTE_W]
	                            : word_q[rom_pkg::BYTE_W-1:0];

	a_no_flip_busy: assert property (@(posedge clk_sys) disable iff (rst)
		!ready |=> $stable(req));

endmodule

//--- src/rom_pkg.sv
// ROM memory map
package rom_pkg;

	// ========================================================================
	// word format
	// ========================================================================

	localparam int BYTE_W = 8;                 // one image byte
	localparam int WORD_W = 16;                // one store word
	localparam int DS_W   = WORD_W / BYTE_W;   // byte strobes per word

	// ========================================================================
	// download image layout
	// ========================================================================

	// byte address width of the loader stream
	localparam int IOCTL_AW = 25;

	// cpu image starts at byte 0 of the stream
	// sound image follows at a fixed byte offset, independent of the cpu image size
	localparam logic [IOCTL_AW-1:0] SND_BYTE_BASE = IOCTL_AW'(65536);

endpackage

//--- src/rom_store.sv
// Dual port ROM store
`timescale 1ns/1ps

module rom_store #(
	parameter int CPU_ADDR_W = 16,
	parameter int SND_ADDR_W = 14
) (
	input  logic                       clk_sys,
	input  logic                       rst,
	// port 1, main cpu
	input  logic                       p1_req,
	input  logic [CPU_ADDR_W-2:0]      p1_addr,
	input  logic [rom_pkg::DS_W-1:0]   p1_ds,
	input  logic                       p1_we,
	input  logic [rom_pkg::WORD_W-1:0] p1_d,
	output logic                       p1_ack,
	output logic [rom_pkg::WORD_W-1:0] p1_q,
	// port 2, sound board
	input  logic                       p2_req,
	input  logic [SND_ADDR_W-2:0]      p2_addr,
	input  logic [rom_pkg::DS_W-1:0]   p2_ds,
	input  logic                       p2_we,
	input  logic [rom_pkg::WORD_W-1:0] p2_d,
	output logic                       p2_ack,
	output logic [rom_pkg::WORD_W-1:0] p2_q
);

	localparam int CPU_WORDS = 2 ** (CPU_ADDR_W - 1);
	localparam int SND_WORDS = 2 ** (SND_ADDR_W - 1);
	localparam int MEM_WORDS = CPU_WORDS + SND_WORDS;
	localparam int MEM_AW    = $clog2(MEM_WORDS);
	localparam logic [MEM_AW-1:0] SND_OFS = MEM_AW'(CPU_WORDS);   // sound region start

	// cpu image has to end below the sound part of the stream
	if (2 ** CPU_ADDR_W > rom_pkg::SND_BYTE_BASE) begin : g_map_check
		$error("cpu image overlaps the sound base of the download stream");
	end

	logic [rom_pkg::WORD_W-1:0] mem [MEM_WORDS];

	port_pkg::store_state_e     state;
	logic                       p1_pend;
	logic                       p2_pend;
	logic [MEM_AW-1:0]          acc_addr;
	logic [rom_pkg::DS_W-1:0]   acc_ds;
	logic [rom_pkg::WORD_W-1:0] acc_d;
	port_pkg::access_op_e       acc_op;

	assign p1_pend = p1_req != p1_ack;
	assign p2_pend = p2_req != p2_ack;

	// ========================================================================
	// arbiter, cpu first
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state  <= port_pkg::ST_IDLE;
			p1_ack <= 1'b0;
			p2_ack <= 1'b0;
		end else begin
			case (state)
				port_pkg::ST_IDLE: begin
					if (p1_pend)
						state <= port_pkg::ST_CPU;
					else if (p2_pend)
						state <= port_pkg::ST_SND;
				end
				port_pkg::ST_CPU: begin
					p1_ack <= p1_req;   // access done this edge
					state  <= port_pkg::ST_IDLE;
				end
				port_pkg::ST_SND: begin
					p2_ack <= p2_req;
					state  <= port_pkg::ST_IDLE;
				end
				default: state <= port_pkg::ST_IDLE;
			endcase
		end
	end

	// ========================================================================
	// access pipeline
	// ========================================================================

	always_comb begin
		if (state == port_pkg::ST_SND) begin
			acc_addr = SND_OFS + MEM_AW'(p2_addr);
			acc_ds   = p2_ds;
			acc_d    = p2_d;
			acc_op   = port_pkg::access_op_e'(p2_we);
		end else begin
			acc_addr = MEM_AW'(p1_addr);
			acc_ds   = p1_ds;
			acc_d    = p1_d;
			acc_op   = port_pkg::access_op_e'(p1_we);
		end
	end

	// q reads the old word, so a write leaves the previous contents there
	always_ff @(posedge clk_sys) begin
		if (state != port_pkg::ST_IDLE) begin
			if (acc_op == port_pkg::OP_WRITE) begin
				for (int i = 0; i < rom_pkg::DS_W; i++) begin
					if (acc_ds[i])
						mem[acc_addr][i*rom_pkg::BYTE_W +: rom_pkg::BYTE_W] <=
							acc_d[i*rom_pkg::BYTE_W +: rom_pkg::BYTE_W];
				end
			end
			if (state == port_pkg::ST_CPU)
				p1_q <= mem[acc_addr];
			else
				p2_q <= mem[acc_addr];
		end
	end

	// ========================================================================
	// checks
	// ========================================================================

	a_p1_no_reflip: assert property (@(posedge clk_sys) disable iff (rst)
		p1_pend |=> $stable(p1_req));

	a_p2_no_reflip: assert property (@(posedge clk_sys) disable iff (rst)
		p2_pend |=> $stable(p2_req));

	// a granted port is still pending while it is served
	a_grant_pending: assert property (@(posedge clk_sys) disable iff (rst)
		(state != port_pkg::ST_IDLE) |-> ((state == port_pkg::ST_CPU) ? p1_pend : p2_pend));

endmodule

//--- src/rom_subsystem.sv
// ROM subsystem top
`timescale 1ns/1ps

module rom_subsystem #(
	parameter int CPU_ADDR_W = 16,
	parameter int SND_ADDR_W = 14
) (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         ioctl_download,
	input  logic                         ioctl_wr,
	input  logic [rom_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [rom_pkg::BYTE_W-1:0]   ioctl_dout,
	input  logic [CPU_ADDR_W-1:0]        cpu_rom_addr,
	input  logic                         cpu_rom_rd,
	input  logic [SND_ADDR_W-1:0]        snd_rom_addr,
	input  logic                         snd_rom_rd,
	output logic [rom_pkg::BYTE_W-1:0]   cpu_rom_do,
	output logic                         cpu_rom_ready,
	output logic [rom_pkg::BYTE_W-1:0]   snd_rom_do,
	output logic                         snd_rom_ready,
	output logic                         rom_loaded,
	output logic                         game_reset
);

	localparam int WA_W = ((CPU_ADDR_W > SND_ADDR_W) ? CPU_ADDR_W : SND_ADDR_W) - 1;

	logic                       wr_p1_req, wr_p2_req;
	logic [WA_W-1:0]            wr_addr;
	logic [rom_pkg::DS_W-1:0]   wr_ds;
	logic [rom_pkg::WORD_W-1:0] wr_d;
	logic                       cpu_req, snd_req;
	logic [CPU_ADDR_W-2:0]      cpu_word;
	logic [SND_ADDR_W-2:0]      snd_word;

	logic                       p1_req, p1_we, p1_ack;
	logic [CPU_ADDR_W-2:0]      p1_addr;
	logic [rom_pkg::DS_W-1:0]   p1_ds;
	logic [rom_pkg::WORD_W-1:0] p1_d, p1_q;
	logic                       p2_req, p2_we, p2_ack;
	logic [SND_ADDR_W-2:0]      p2_addr;
	logic [rom_pkg::DS_W-1:0]   p2_ds;
	logic [rom_pkg::WORD_W-1:0] p2_d, p2_q;

	download_writer #(.CPU_ADDR_W(CPU_ADDR_W), .SND_ADDR_W(SND_ADDR_W)) writer0 (
		.clk_sys, .rst, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.p1_req(wr_p1_req), .p2_req(wr_p2_req),
		.wr_addr, .wr_ds, .wr_d, .rom_loaded, .game_reset
	);

	// ========================================================================
	// port steering
	// ========================================================================

	// only one side toggles at a time, so xor keeps the phase across the hand-over
	assign p1_req  = wr_p1_req ^ cpu_req;
	assign p1_addr = ioctl_download ? wr_addr[CPU_ADDR_W-2:0] : cpu_word;
	assign p1_ds   = ioctl_download ? wr_ds : {rom_pkg::DS_W{1'b1}};
	assign p1_we   = ioctl_download ? port_pkg::OP_WRITE : port_pkg::OP_READ;
	assign p1_d    = wr_d;   // ignored on reads

	assign p2_req  = wr_p2_req ^ snd_req;
	assign p2_addr = ioctl_download ? wr_addr[SND_ADDR_W-2:0] : snd_word;
	assign p2_ds   = ioctl_download ? wr_ds : {rom_pkg::DS_W{1'b1}};
	assign p2_we   = ioctl_download ? port_pkg::OP_WRITE : port_pkg::OP_READ;
	assign p2_d    = wr_d;

	rom_store #(.CPU_ADDR_W(CPU_ADDR_W), .SND_ADDR_W(SND_ADDR_W)) store0 (
		.clk_sys, .rst,
		.p1_req, .p1_addr, .p1_ds, .p1_we, .p1_d, .p1_ack, .p1_q,
		.p2_req, .p2_addr, .p2_ds, .p2_we, .p2_d, .p2_ack, .p2_q
	);

	// fetch units follow the game reset and start empty after a download
	rom_fetch #(.ADDR_W(CPU_ADDR_W)) cpu_fetch (
		.clk_sys, .rst(game_reset),
		.rom_addr(cpu_rom_addr), .rom_rd(cpu_rom_rd), .ack(p1_ack), .q(p1_q),
		.req(cpu_req), .word_addr(cpu_word), .rom_do(cpu_rom_do), .ready(cpu_rom_ready)
	);

	rom_fetch #(.ADDR_W(SND_ADDR_W)) snd_fetch (
		.clk_sys, .rst(game_reset),
		.rom_addr(snd_rom_addr), .rom_rd(snd_rom_rd), .ack(p2_ack), .q(p2_q),
		.req(snd_req), .word_addr(snd_word), .rom_do(snd_rom_do), .ready(snd_rom_ready)
	);

endmodule

//--- verif/tb_rom_subsystem.sv
// ROM subsystem testbench
`timescale 1ns/1ps

module tb_rom_subsystem;

	localparam int CPU_AW     = 12;   // small images keep the download short
	localparam int SND_AW     = 10;
	localparam int CPU_BYTES  = 2 ** CPU_AW;
	localparam int SND_BYTES  = 2 ** SND_AW;
	localparam int IOCTL_AW   = rom_pkg::IOCTL_AW;
	localparam int WAIT_LIMIT = 50;   // cycles per wait

	logic                       clk_sys;
	logic                       rst;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [IOCTL_AW-1:0]        ioctl_addr;
	logic [rom_pkg::BYTE_W-1:0] ioctl_dout;
	logic [CPU_AW-1:0]          cpu_rom_addr;
	logic                       cpu_rom_rd;
	logic [SND_AW-1:0]          snd_rom_addr;
	logic                       snd_rom_rd;
	logic [rom_pkg::BYTE_W-1:0] cpu_rom_do;
	logic                       cpu_rom_ready;
	logic [rom_pkg::BYTE_W-1:0] snd_rom_do;
	logic                       snd_rom_ready;
	logic                       rom_loaded;
	logic                       game_reset;

	logic [7:0] cpu_img [CPU_BYTES];   // expected image, cpu part
	logic [7:0] snd_img [SND_BYTES];   // sound part, at SND_BYTE_BASE in the stream
	integer     seed;

	rom_subsystem #(.CPU_ADDR_W(CPU_AW), .SND_ADDR_W(SND_AW)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// helpers
	// ========================================================================

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			abort_run($sformatf("FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	task automatic build_image();
		int r;
		seed = 53984;
		for (int i = 0; i < CPU_BYTES; i++) begin
			r = $random(seed);
			cpu_img[i] = r[7:0];
		end
		for (int i = 0; i < SND_BYTES; i++) begin
			r = $random(seed);
			snd_img[i] = r[7:0];
		end
	endtask

	// one strobe, then idle so strobes stay 4 cycles apart
	task automatic send_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		ioctl_addr <= a;
		ioctl_dout <= d;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic wait_ready(input bit on_cpu, input bit on_snd, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while ((on_cpu && !cpu_rom_ready) || (on_snd && !snd_rom_ready)) begin
			if (n == WAIT_LIMIT)
				abort_run($sformatf("timed out waiting for %s to finish", what));
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic cpu_read(input logic [CPU_AW-1:0] a);
		@(posedge clk_sys);
		cpu_rom_addr <= a;
		cpu_rom_rd   <= 1'b1;
		@(posedge clk_sys);   // fetch unit reacts on this edge
		wait_ready(1'b1, 1'b0, "the CPU fetch");
		compare_value(32'(cpu_rom_do), 32'(cpu_img[a]), $sformatf("CPU byte %0h", a));
	endtask

	task automatic snd_read(input logic [SND_AW-1:0] a);
		@(posedge clk_sys);
		snd_rom_addr <= a;
		snd_rom_rd   <= 1'b1;
		@(posedge clk_sys);
		wait_ready(1'b0, 1'b1, "the sound fetch");
		compare_value(32'(snd_rom_do), 32'(snd_img[a]), $sformatf("sound byte %0h", a));
	endtask

	// ========================================================================
	// tests
	// ========================================================================

	task automatic test_after_reset();
		@(negedge clk_sys);
		compare_value(32'(game_reset), 32'd1, "game_reset after reset");
		compare_value(32'(rom_loaded), 32'd0, "rom_loaded after reset");
		compare_value(32'(cpu_rom_ready), 32'd1, "CPU ready after reset");
		compare_value(32'(snd_rom_ready), 32'd1, "sound ready after reset");
	endtask

	task automatic test_download();
		int n;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (int i = 0; i < CPU_BYTES; i++)
			send_byte(IOCTL_AW'(i), cpu_img[i]);
		for (int i = 0; i < SND_BYTES; i++)
			send_byte(rom_pkg::SND_BYTE_BASE + IOCTL_AW'(i), snd_img[i]);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!rom_loaded) begin
			if (n == WAIT_LIMIT)
				abort_run("timed out waiting for rom_loaded after the download");
			n++;
			@(negedge clk_sys);
		end
		// rom_loaded two cycles after the download ends, game reset one cycle later
		compare_value(32'(n), 32'd2, "cycles from download end to rom_loaded");
		compare_value(32'(game_reset), 32'd1, "game_reset as rom_loaded rises");
		@(negedge clk_sys);
		compare_value(32'(rom_loaded), 32'd1, "rom_loaded after download");
		compare_value(32'(game_reset), 32'd0, "game_reset after download");
	endtask

	task automatic test_cpu_reads();
		int r;
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			cpu_read(r[CPU_AW-1:0]);
		end
	endtask

	task automatic test_snd_reads();
		int r;
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			snd_read(r[SND_AW-1:0]);
		end
	endtask

	// both ports pending together, cpu served first
	task automatic test_dual_reads();
		int                r;
		logic [CPU_AW-1:0] ca;
		logic [SND_AW-1:0] sa;
		for (int i = 0; i < 10; i++) begin
			r  = $random(seed);
			ca = r[CPU_AW-1:0];
			r  = $random(seed);
			sa = r[SND_AW-1:0];
			@(posedge clk_sys);
			cpu_rom_addr <= ca;
			snd_rom_addr <= sa;
			@(posedge clk_sys);
			wait_ready(1'b1, 1'b1, "both fetches");
			compare_value(32'(cpu_rom_do), 32'(cpu_img[ca]), $sformatf("CPU byte %0h", ca));
			compare_value(32'(snd_rom_do), 32'(snd_img[sa]), $sformatf("sound byte %0h", sa));
		end
	endtask

	task automatic test_same_word();
		int                r;
		logic [CPU_AW-1:0] a;
		logic              req0;
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			a = r[CPU_AW-1:0];
			cpu_read(a);
			req0 = dut0.cpu_req;
			a    = a ^ CPU_AW'(1);   // other half of the held word
			@(posedge clk_sys);
			cpu_rom_addr <= a;
			repeat (4) begin
				@(negedge clk_sys);
				compare_value(32'(cpu_rom_ready), 32'd1, "ready on a held word");
			end
			compare_value(32'(cpu_rom_do), 32'(cpu_img[a]), $sformatf("CPU byte %0h", a));
			compare_value(32'(dut0.cpu_req), 32'(req0), "no new request on a held word");
		end
	endtask

	initial begin
		rst            = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cpu_rom_addr   = '0;
		cpu_rom_rd     = 1'b0;
		snd_rom_addr   = '0;
		snd_rom_rd     = 1'b0;
		build_image();
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		test_after_reset();
		test_download();
		test_cpu_reads();
		test_snd_reads();
		test_dual_reads();
		test_same_word();
		$display("Testbench passed");
		$finish;
	end

endmodule
